/* logic/sort_params.svh */
`ifndef SORT_PARAMS_SVH
`define SORT_PARAMS_SVH

// sizing for the keyed record sorter

// width of the sort key in bits
// only this field takes part in the compare
`define SORT_KEY_W 8

// width of the payload tag in bits
// the tag travels with its key through every stage
`define SORT_TAG_W 4

// records per quad
// the network is wired for exactly four
// so this value only shapes the vector type
`define SORT_ITEMS 4

`endif

/* logic/sort_pkg.sv */
package sort_pkg;

  `include "sort_params.svh"

  // sort key, compared as unsigned
  typedef logic [`SORT_KEY_W-1:0] key_t;

  // payload tag carried alongside the key
  typedef logic [`SORT_TAG_W-1:0] tag_t;

  // one record
  // key sits in the upper bits, tag below it
  typedef struct packed {
    key_t key;
    tag_t tag;
  } record_t;

  // the two records seen by one compare cell
  // after the cell, lo holds the smaller key
  typedef struct packed {
    record_t hi;
    record_t lo;
  } record_pair_t;

  // one quad of records
  // index 0 is the lowest position and ends up with the smallest key
  typedef record_t [`SORT_ITEMS-1:0] record_vec_t;

endpackage

/* logic/compare_and_swap.sv */
module compare_and_swap
  import sort_pkg::*;
#(
  // set to 1 to allow an exchange of equal keys
  // when swap_on_equal_i asks for it
  parameter bit cond_swap_on_equal_p = 1'b0
) (
  input  record_pair_t data_i,
  input  logic         swap_on_equal_i,
  output record_pair_t data_o,
  output logic         swapped_o
);

  // keys pulled out of the pair
  key_t hi_key;
  key_t lo_key;

  // compare results
  logic lo_greater;
  logic keys_equal;

  // equal-key exchange, only live in the conditional variant
  logic tie_swap;

  // final exchange decision
  logic do_swap;

  assign hi_key = data_i.hi.key;
  assign lo_key = data_i.lo.key;

  // strict compare keeps equal keys where they are by default
  assign lo_greater = lo_key > hi_key;
  assign keys_equal = lo_key == hi_key;

  // a tie is exchanged only when the cell is built for it
  // and the caller says an earlier stage reordered these records
  assign tie_swap = cond_swap_on_equal_p && swap_on_equal_i && keys_equal;

  assign do_swap = lo_greater | tie_swap;

  // route the pair, exchanging both key and tag together
  always_comb begin
    if (do_swap) begin
      data_o.hi = data_i.lo;
      data_o.lo = data_i.hi;
    end else begin
      data_o = data_i;
    end
  end

  // level flag, purely combinational
  // the network registers it where a later stage needs it
  assign swapped_o = do_swap;

endmodule

/* logic/sort_network_4.sv */
module sort_network_4
  import sort_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        valid_i,
  input  record_vec_t records_i,
  output logic        valid_o,
  output record_vec_t records_o
);

  // records after each compare stage
  record_vec_t s1;
  record_vec_t s2;
  record_vec_t s3;

  // pair buses into and out of each cell
  record_pair_t cas0_in;
  record_pair_t cas0_out;
  record_pair_t cas1_in;
  record_pair_t cas1_out;
  record_pair_t cas2_in;
  record_pair_t cas2_out;
  record_pair_t cas3_in;
  record_pair_t cas3_out;
  record_pair_t cas4_in;
  record_pair_t cas4_out;

  // stage-2 exchange flags
  // either one leaves the earlier of two tied middle records in position 2
  logic swapped_2_0;
  logic swapped_3_1;

  // mid-pipeline register between stages 2 and 3
  logic        mid_valid_q;
  record_vec_t mid_records_q;
  logic        mid_tie_swap_q;

  // output register after stage 3
  logic        out_valid_q;
  record_vec_t out_records_q;

  // stage 1
  // order the lower pair <1,0> and the upper pair <3,2>
  assign cas0_in = '{hi: records_i[1], lo: records_i[0]};
  assign cas1_in = '{hi: records_i[3], lo: records_i[2]};

  compare_and_swap #(
    .cond_swap_on_equal_p(1'b0)
  ) cas_0 (
    .data_i         (cas0_in),
    .swap_on_equal_i(1'b0),
    .data_o         (cas0_out),
    .swapped_o      ()
  );

  compare_and_swap #(
    .cond_swap_on_equal_p(1'b0)
  ) cas_1 (
    .data_i         (cas1_in),
    .swap_on_equal_i(1'b0),
    .data_o         (cas1_out),
    .swapped_o      ()
  );

  // most significant element is position 3
  assign s1 = {cas1_out.hi, cas1_out.lo, cas0_out.hi, cas0_out.lo};

  // stage 2
  // <2,0> settles the minimum, <3,1> settles the maximum
  assign cas2_in = '{hi: s1[2], lo: s1[0]};
  assign cas3_in = '{hi: s1[3], lo: s1[1]};

  compare_and_swap #(
    .cond_swap_on_equal_p(1'b0)
  ) cas_2 (
    .data_i         (cas2_in),
    .swap_on_equal_i(1'b0),
    .data_o         (cas2_out),
    .swapped_o      (swapped_2_0)
  );

  compare_and_swap #(
    .cond_swap_on_equal_p(1'b0)
  ) cas_3 (
    .data_i         (cas3_in),
    .swap_on_equal_i(1'b0),
    .data_o         (cas3_out),
    .swapped_o      (swapped_3_1)
  );

  // positions 0 and 3 are final from here on
  assign s2 = {cas3_out.hi, cas2_out.hi, cas3_out.lo, cas2_out.lo};

  // valid of the mid register, cleared on reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mid_valid_q <= 1'b0;
    end else begin
      mid_valid_q <= valid_i;
    end
  end

  // stage-2 records and the tie flag load together with valid
  // and otherwise keep the previous quad
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      mid_records_q  <= s2;
      mid_tie_swap_q <= swapped_2_0 | swapped_3_1;
    end
  end

  // stage 3
  // middle pair <2,1>, also exchanged on equal keys when a stage-2 cell swapped
  // since that exchange put the earlier record above the later one
  assign cas4_in = '{hi: mid_records_q[2], lo: mid_records_q[1]};

  compare_and_swap #(
    .cond_swap_on_equal_p(1'b1)
  ) cas_4 (
    .data_i         (cas4_in),
    .swap_on_equal_i(mid_tie_swap_q),
    .data_o         (cas4_out),
    .swapped_o      ()
  );

  // outer positions pass straight through
  assign s3 = {mid_records_q[3], cas4_out.hi, cas4_out.lo, mid_records_q[0]};

  // output valid pulse, one per quad
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= mid_valid_q;
    end
  end

  // sorted quad, held between pulses
  always_ff @(posedge clk_i) begin
    if (mid_valid_q) begin
      out_records_q <= s3;
    end
  end

  assign valid_o   = out_valid_q;
  assign records_o = out_records_q;

endmodule

/* logic/sort_unit.sv */
module sort_unit
  import sort_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  // one strobe per quad, no back-pressure
  input  logic        valid_i,
  input  record_vec_t records_i,
  // pulse three cycles after the strobe, in input order
  output logic        valid_o,
  output record_vec_t records_o
);

  // input capture register
  logic        in_valid_q;
  record_vec_t in_records_q;

  // strobe capture, cleared on reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= valid_i;
    end
  end

  // quad is sampled only on a strobe
  // between strobes the register keeps the last quad
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      in_records_q <= records_i;
    end
  end

  // two more register stages inside the network
  // so the total latency is three cycles
  sort_network_4 network_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (in_valid_q),
    .records_i(in_records_q),
    .valid_o  (valid_o),
    .records_o(records_o)
  );

endmodule

/* verif/sort_checker.sv */
`include "sort_params.svh"

module sort_checker
  import sort_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  // DUT input side, strobe plus the quad it should turn into
  input  logic        in_valid_i,
  input  record_vec_t expected_i,
  // DUT output side
  input  logic        out_valid_i,
  input  record_vec_t out_records_i,
  // end of stimulus, look for quads that never came out
  input  logic        done_i,
  output int          passed_o,
  output int          failed_o,
  output int          pending_o
);

  // expected quads and their strobe edge, oldest first
  record_vec_t exp_q[$];
  int          start_q[$];

  int   cycle;
  int   test_num;
  logic done_seen = 1'b0;

  always @(posedge clk_i) begin : watch
    record_vec_t exp_quad;
    int          start;
    int          errs;
    int          n;
    // edge count, the strobe edge is tagged with it
    cycle = cycle + 1;
    if (!reset_i && in_valid_i === 1'b1) begin
      exp_q.push_back(expected_i);
      start_q.push_back(cycle);
    end
    // outputs seen here were set on the previous edge
    // before edge 1 they are still unknown
    if (cycle > 1) begin
      if (out_valid_i === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("valid_o went high at time %0t with no quad pending", $time);
          failed_o = failed_o + 1;
        end else begin
          exp_quad = exp_q.pop_front();
          start    = start_q.pop_front();
          errs     = 0;
          test_num = test_num + 1;
          // a strobe seen at edge k shows up on valid_o at edge k+3
          if (cycle - start != 3) begin
            $display("test %0d came out %0d cycles after its strobe instead of 3",
                     test_num, cycle - start);
            errs = errs + 1;
          end
          for (n = 0; n < `SORT_ITEMS; n = n + 1) begin
            if (out_records_i[n] !== exp_quad[n]) begin
              $display("ERROR time=%0t records_o[%0d] exp key=%0d tag=%0d got key=%0d tag=%0d",
                       $time, n, exp_quad[n].key, exp_quad[n].tag,
                       out_records_i[n].key, out_records_i[n].tag);
              errs = errs + 1;
            end
          end
          if (errs == 0) begin
            $display("test %0d passed", test_num);
            passed_o = passed_o + 1;
          end else begin
            $display("test %0d failed", test_num);
            failed_o = failed_o + 1;
          end
        end
      end else if (out_valid_i !== 1'b0) begin
        $display("valid_o is unknown at time %0t", $time);
        failed_o = failed_o + 1;
      end
    end
    // leftovers count as failed tests
    if (done_i && !done_seen) begin
      done_seen = 1'b1;
      if (exp_q.size() != 0) begin
        $display("%0d quads were sent but never came out", exp_q.size());
        failed_o = failed_o + exp_q.size();
      end
    end
    pending_o = exp_q.size();
  end

endmodule

/* verif/sort_unit_tb.sv */
`include "sort_params.svh"

module sort_unit_tb
  import sort_pkg::*;
();

  // DUT ports
  logic        clk_i;
  logic        reset_i;
  logic        valid_i;
  record_vec_t records_i;
  logic        valid_o;
  record_vec_t records_o;

  // expected quad, driven next to each strobe
  record_vec_t expected;
  logic        done;
  int          passed;
  int          failed;
  int          pending;

  // stimulus table, one entry per row
  record_vec_t in_tab[$];
  record_vec_t exp_tab[$];
  int          gap_tab[$];
  int          total_gaps;

  integer seed;
  int     cycle_count;
  int     cycle_limit;

  sort_unit dut_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (valid_i),
    .records_i(records_i),
    .valid_o  (valid_o),
    .records_o(records_o)
  );

  sort_checker check_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .in_valid_i   (valid_i),
    .expected_i   (expected),
    .out_valid_i  (valid_o),
    .out_records_i(records_o),
    .done_i       (done),
    .passed_o     (passed),
    .failed_o     (failed),
    .pending_o    (pending)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // quad from key/tag pairs, position 0 first
  function automatic record_vec_t build_quad(input key_t k0, input tag_t t0,
                                             input key_t k1, input tag_t t1,
                                             input key_t k2, input tag_t t2,
                                             input key_t k3, input tag_t t3);
    record_vec_t q;
    q[0] = '{key: k0, tag: t0};
    q[1] = '{key: k1, tag: t1};
    q[2] = '{key: k2, tag: t2};
    q[3] = '{key: k3, tag: t3};
    return q;
  endfunction

  // ascending insertion sort, strict compare keeps ties in input order
  function automatic record_vec_t insertion_sort(input record_vec_t q);
    record_vec_t r;
    record_t     cur;
    int          i;
    int          j;
    r = q;
    for (i = 1; i < `SORT_ITEMS; i = i + 1) begin
      cur = r[i];
      j   = i - 1;
      while (j >= 0 && r[j].key > cur.key) begin
        r[j+1] = r[j];
        j      = j - 1;
      end
      r[j+1] = cur;
    end
    return r;
  endfunction

  task automatic add_row(input record_vec_t in_quad, input record_vec_t exp_quad,
                         input int gap);
    in_tab.push_back(in_quad);
    exp_tab.push_back(exp_quad);
    gap_tab.push_back(gap);
    total_gaps = total_gaps + gap;
  endtask

  // run limit, set once the table is built
  initial begin : watchdog
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_i);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : main
    record_vec_t quad;
    int          row;
    int          p;
    seed      = 75;
    reset_i   = 1'b1;
    valid_i   = 1'b0;
    records_i = '0;
    expected  = '0;
    done      = 1'b0;
    // reversed, sorted, mixed
    add_row(build_quad(40, 0, 30, 1, 20, 2, 10, 3), build_quad(10, 3, 20, 2, 30, 1, 40, 0), 0);
    add_row(build_quad(5, 0, 6, 1, 7, 2, 8, 3), build_quad(5, 0, 6, 1, 7, 2, 8, 3), 0);
    add_row(build_quad(7, 0, 200, 1, 3, 2, 90, 3), build_quad(3, 2, 7, 0, 90, 3, 200, 1), 2);
    // all equal, then pairs of ties
    add_row(build_quad(9, 0, 9, 1, 9, 2, 9, 3), build_quad(9, 0, 9, 1, 9, 2, 9, 3), 0);
    add_row(build_quad(5, 0, 2, 1, 5, 2, 2, 3), build_quad(2, 1, 2, 3, 5, 0, 5, 2), 1);
    add_row(build_quad(3, 0, 1, 1, 3, 2, 1, 3), build_quad(1, 1, 1, 3, 3, 0, 3, 2), 0);
    // <3,1> swaps in stage 2, then <2,1> ties in stage 3
    add_row(build_quad(1, 0, 5, 1, 3, 2, 3, 3), build_quad(1, 0, 3, 2, 3, 3, 5, 1), 0);
    // <2,0> swaps in stage 2, then <2,1> ties in stage 3
    add_row(build_quad(2, 0, 2, 1, 1, 2, 3, 3), build_quad(1, 2, 2, 0, 2, 1, 3, 3), 0);
    add_row(build_quad(0, 0, 7, 1, 7, 2, 7, 3), build_quad(0, 0, 7, 1, 7, 2, 7, 3), 0);
    add_row(build_quad(255, 0, 0, 1, 128, 2, 0, 3), build_quad(0, 1, 0, 3, 128, 2, 255, 0), 3);
    // random rows, narrow keys for lots of ties
    repeat (200) begin
      for (p = 0; p < `SORT_ITEMS; p = p + 1) begin
        quad[p].key = $unsigned($random(seed)) % 4;
        quad[p].tag = p;
      end
      add_row(quad, insertion_sort(quad), $unsigned($random(seed)) % 3);
    end
    cycle_limit = in_tab.size() * 2 + total_gaps + 20;
    // reset spans four rising edges
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (row = 0; row < in_tab.size(); row = row + 1) begin
      @(negedge clk_i);
      valid_i   = 1'b1;
      records_i = in_tab[row];
      expected  = exp_tab[row];
      repeat (gap_tab[row]) begin
        @(negedge clk_i);
        valid_i = 1'b0;
      end
    end
    @(negedge clk_i);
    valid_i = 1'b0;
    // give the three-stage pipeline time to empty
    for (p = 0; p < 4 && pending != 0; p = p + 1) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    done = 1'b1;
    @(negedge clk_i);
    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0 && passed == in_tab.size()) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* sort_unit.f */
+incdir+logic
logic/sort_pkg.sv
logic/compare_and_swap.sv
logic/sort_network_4.sv
logic/sort_unit.sv
verif/sort_checker.sv
verif/sort_unit_tb.sv

/* Bender.yml */
package:
  name: sort_unit

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/sort_pkg.sv
      - logic/compare_and_swap.sv
      - logic/sort_network_4.sv
      - logic/sort_unit.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/sort_checker.sv
      - verif/sort_unit_tb.sv
